/* src/audio_bus_pkg.sv */
// ****************************************
// Wishbone classic request/response types
// register map of the audio block
// control register bit positions
// ****************************************

package audio_bus_pkg;

    // master to slave, held until ack
    typedef struct packed {
        logic       cyc;  // bus cycle in progress
        logic       stb;  // strobe, valid transfer
        logic       we;   // 1 = write
        logic [2:0] adr;  // register select
        logic [7:0] dat;  // write data
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic       ack;  // one-cycle registered ack
        logic [7:0] dat;  // read data, valid with ack
    } wb_rsp_t;

    // register addresses, 4..7 unmapped
    localparam logic [2:0] REG_FREQ_LO = 3'd0;  // phase increment low byte
    localparam logic [2:0] REG_FREQ_HI = 3'd1;  // phase increment high byte
    localparam logic [2:0] REG_VOLUME  = 3'd2;  // amplitude 0..255
    localparam logic [2:0] REG_CTRL    = 3'd3;  // enable / waveform select

    localparam int CTRL_ENABLE_BIT = 0;  // voice runs when set
    localparam int CTRL_SAW_BIT    = 1;  // 1 = sawtooth, 0 = square

endpackage

/* src/audio_dsp_pkg.sv */
// ****************************************
// audio sample type
// voice configuration struct
// waveform, mixer and DAC constants
// ****************************************

package audio_dsp_pkg;

    typedef logic signed [15:0] sample_t;  // signed 16-bit pcm

    // voice setup, driven straight from the registers
    typedef struct packed {
        logic [15:0] freq;    // phase increment per tick
        logic [7:0]  volume;  // unsigned amplitude
        logic        enable;  // 0 holds phase at zero
        logic        saw;     // waveform select
    } voice_cfg_t;

    // click from the port line, fixed magnitude
    localparam sample_t CLICK_LEVEL = 16'sh0800;

    // square peak is volume << 7, max 32640
    localparam int SQUARE_SHIFT = 7;

    // clamp limits of the mixer output
    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    // 16-bit sum plus carry out
    localparam int DAC_ACC_W = 17;

endpackage

/* src/audio_reg_decode.sv */
// ****************************************
// Wishbone classic slave, registered ack
// voice registers: freq lo/hi, volume, ctrl
// read mux registered to line up with ack
// ****************************************

`timescale 1ns/1ns

module audio_reg_decode (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  audio_bus_pkg::wb_req_t   wb_req_i,
    output audio_bus_pkg::wb_rsp_t   wb_rsp_o,
    output audio_dsp_pkg::voice_cfg_t voice_cfg_o
);
    import audio_bus_pkg::*;

    logic [7:0] freq_lo_q;  // REG_FREQ_LO
    logic [7:0] freq_hi_q;  // REG_FREQ_HI
    logic [7:0] volume_q;   // REG_VOLUME
    logic [7:0] ctrl_q;     // REG_CTRL, all 8 bits kept for readback

    logic       ack_q;      // one pulse per access
    logic [7:0] rd_dat_q;   // read data, valid with ack
    logic [7:0] rd_next;    // addressed register, combinational
    logic       access;     // new transfer this cycle

    // new transfer only while ack is low, so a held stb gets one ack
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    always_comb begin
        case (wb_req_i.adr)
            REG_FREQ_LO: rd_next = freq_lo_q;
            REG_FREQ_HI: rd_next = freq_hi_q;
            REG_VOLUME:  rd_next = volume_q;
            REG_CTRL:    rd_next = ctrl_q;
            default:     rd_next = 8'h00;  // unmapped reads 0
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q     <= 1'b0;
            rd_dat_q  <= 8'h00;
            freq_lo_q <= 8'h00;
            freq_hi_q <= 8'h00;
            volume_q  <= 8'h00;
            ctrl_q    <= 8'h00;
        end else begin
            ack_q <= access;  // ack one edge after request seen
            if (access) begin
                rd_dat_q <= rd_next;  // lands with ack
                if (wb_req_i.we) begin  // write on the ack edge
                    case (wb_req_i.adr)
                        REG_FREQ_LO: freq_lo_q <= wb_req_i.dat;
                        REG_FREQ_HI: freq_hi_q <= wb_req_i.dat;
                        REG_VOLUME:  volume_q  <= wb_req_i.dat;
                        REG_CTRL:    ctrl_q    <= wb_req_i.dat;
                        default:     ;  // unmapped, dropped
                    endcase
                end
            end
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_dat_q;

    // voice sees new settings right after the ack edge
    assign voice_cfg_o.freq   = {freq_hi_q, freq_lo_q};
    assign voice_cfg_o.volume = volume_q;
    assign voice_cfg_o.enable = ctrl_q[CTRL_ENABLE_BIT];
    assign voice_cfg_o.saw    = ctrl_q[CTRL_SAW_BIT];

endmodule

/* src/tone_voice.sv */
// ****************************************
// tone voice
// 16-bit phase accumulator on tick enable
// square or sawtooth, scaled by volume
// ****************************************

`timescale 1ns/1ns

module tone_voice (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      tick_en_i,
    input  audio_dsp_pkg::voice_cfg_t voice_cfg_i,
    output audio_dsp_pkg::sample_t    sample_o
);
    import audio_dsp_pkg::*;

    logic [15:0]        phase_q;     // wraps mod 2^16
    sample_t            sample_q;    // registered waveform
    sample_t            sq_amp;      // volume << SQUARE_SHIFT
    sample_t            sq_val;      // +/- sq_amp by phase msb
    logic signed [24:0] saw_prod;    // signed phase * volume
    logic signed [24:0] saw_scaled;  // product >>> 8
    sample_t            saw_val;     // fits, |value| <= 32640
    sample_t            shaped;      // selected waveform

    // phase advances only on ticks, held at zero while off
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            phase_q <= 16'h0000;
        end else if (!voice_cfg_i.enable) begin
            phase_q <= 16'h0000;  // known start of next note
        end else if (tick_en_i) begin
            phase_q <= phase_q + voice_cfg_i.freq;  // carry dropped
        end
    end

    // square: high half of the cycle positive
    assign sq_amp = {8'h00, voice_cfg_i.volume} << SQUARE_SHIFT;
    assign sq_val = phase_q[15] ? -sq_amp : sq_amp;

    // sawtooth: phase read as signed ramp, volume zero-extended
    assign saw_prod   = $signed(phase_q) * $signed({1'b0, voice_cfg_i.volume});
    assign saw_scaled = saw_prod >>> 8;
    assign saw_val    = saw_scaled[15:0];

    assign shaped = voice_cfg_i.saw ? saw_val : sq_val;

    // one register stage, the multiply folds into it
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sample_q <= '0;
        end else if (!voice_cfg_i.enable) begin
            sample_q <= '0;  // silent when off
        end else begin
            sample_q <= shaped;
        end
    end

    assign sample_o = sample_q;

endmodule

/* src/delta_sigma_dac.sv */
// ****************************************
// first-order delta-sigma modulator
// signed 16-bit in, 1-bit density out
// ****************************************

`timescale 1ns/1ns

module delta_sigma_dac (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  audio_dsp_pkg::sample_t dac_i,
    output logic                   dac_o
);
    import audio_dsp_pkg::*;

    logic [DAC_ACC_W-2:0] biased;  // offset binary, 0x8000 = silence
    logic [DAC_ACC_W-1:0] acc_q;   // msb is the carry out

    // flip to offset binary: -32768 -> 0, +32767 -> 0xffff
    assign biased = dac_i + 16'h8000;

    // carry is dropped each cycle, only the residue is kept
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            acc_q <= '0;
        end else begin
            acc_q <= {1'b0, acc_q[DAC_ACC_W-2:0]} + {1'b0, biased};
        end
    end

    assign dac_o = acc_q[DAC_ACC_W-1];  // ones density tracks level

endmodule

/* src/audio_mixer.sv */
// ****************************************
// mixer: voice plus port-line click
// saturates to sample range, registered
// drives the delta-sigma DAC
// ****************************************

`timescale 1ns/1ns

module audio_mixer (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  audio_dsp_pkg::sample_t voice_i,
    input  logic                   cb2_i,
    input  logic                   diag_i,
    output logic                   audio_o
);
    import audio_dsp_pkg::*;

    sample_t            click;  // +/- CLICK_LEVEL
    logic signed [16:0] sum;    // one guard bit, no overflow
    sample_t            sat;    // clamped sum
    sample_t            mix_q;  // registered mixer output

    // click high only when the line and diag are both set
    assign click = (cb2_i && diag_i) ? CLICK_LEVEL : -CLICK_LEVEL;

    assign sum = {voice_i[15], voice_i} + {click[15], click};  // sign-extended add

    always_comb begin
        if (sum > SAMPLE_MAX) begin
            sat = SAMPLE_MAX;  // positive clip
        end else if (sum < SAMPLE_MIN) begin
            sat = SAMPLE_MIN;  // negative clip
        end else begin
            sat = sum[15:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mix_q <= '0;
        end else begin
            mix_q <= sat;
        end
    end

    delta_sigma_dac dac (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .dac_i  (mix_q),
        .dac_o  (audio_o)
    );

endmodule

/* src/audio_top.sv */
// ****************************************
// audio block top level
// register decode -> tone voice -> mixer/DAC
// ****************************************

`timescale 1ns/1ns

module audio_top (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  audio_bus_pkg::wb_req_t wb_req_i,  // CPU-side Wishbone
    output audio_bus_pkg::wb_rsp_t wb_rsp_o,
    input  logic                   tick_en_i,  // voice tick enable
    input  logic                   cb2_i,      // port line for the click
    input  logic                   diag_i,     // gates the click
    output logic                   audio_o     // 1-bit audio
);
    import audio_dsp_pkg::*;

    voice_cfg_t voice_cfg;     // register outputs to the voice
    sample_t    voice_sample;  // voice to mixer

    audio_reg_decode decode (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .voice_cfg_o(voice_cfg)
    );

    tone_voice voice (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .tick_en_i  (tick_en_i),
        .voice_cfg_i(voice_cfg),
        .sample_o   (voice_sample)
    );

    audio_mixer mixer (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .voice_i(voice_sample),
        .cb2_i  (cb2_i),
        .diag_i (diag_i),
        .audio_o(audio_o)
    );

endmodule

/* sim/audio_tb.sv */
// ****************************************
// directed testbench for audio_top
// Wishbone read/write tasks with timeouts
// cycle model: regs, phase, voice, mixer, DAC
// ****************************************

`timescale 1ns/1ns

module audio_tb;
    import audio_bus_pkg::*;

    logic clk_i = 1'b0;
    logic reset_i, tick_en_i, cb2_i, diag_i, audio_o;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    int errors = 0;       // all failed checks
    int accesses = 0;     // bus cycles started
    int ack_pulses = 0;   // ack cycles seen
    logic cmp_en = 1'b0;  // per-cycle compare on after reset
    logic ack_prev = 1'b0;

    // model state, fed from the DUT input ports only
    logic        m_ack;
    logic        m_access;
    logic [15:0] m_freq, m_phase;
    logic [7:0]  m_vol, m_ctrl;
    int          m_voice, m_mix;
    logic [16:0] m_acc;   // bit 16 is the expected audio_o

    audio_top UUT (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .tick_en_i(tick_en_i),
        .cb2_i    (cb2_i),
        .diag_i   (diag_i),
        .audio_o  (audio_o)
    );

    always #20 clk_i = ~clk_i;  // 40 ns period

    // square is +/- volume*128 by phase msb, saw is signed phase * volume / 256
    function automatic int voice_level(logic [15:0] phase, logic [7:0] vol, logic saw);
        int ramp;
        int amp;
        int lvl;
        ramp = int'($signed(phase));
        amp = int'(vol) * 128;
        if (saw) lvl = (ramp * int'(vol)) >>> 8;
        else lvl = phase[15] ? -amp : amp;
        return lvl;
    endfunction

    function automatic int clamp16(int s);
        int r;
        if (s > 32767) r = 32767;
        else if (s < -32768) r = -32768;
        else r = s;
        return r;
    endfunction

    assign m_access = wb_req.cyc && wb_req.stb && !m_ack;

    always @(posedge clk_i) begin
        if (reset_i) begin
            m_ack <= 1'b0;
            m_freq <= '0;
            m_vol <= '0;
            m_ctrl <= '0;
            m_phase <= '0;
            m_voice <= 0;
            m_mix <= 0;
            m_acc <= '0;
        end else begin
            m_ack <= m_access;
            if (m_access && wb_req.we) begin
                case (wb_req.adr)
                    3'd0: m_freq[7:0] <= wb_req.dat;
                    3'd1: m_freq[15:8] <= wb_req.dat;
                    3'd2: m_vol <= wb_req.dat;
                    3'd3: m_ctrl <= wb_req.dat;
                    default: ;  // unmapped
                endcase
            end
            if (!m_ctrl[0]) m_phase <= '0;
            else if (tick_en_i) m_phase <= m_phase + m_freq;
            m_voice <= m_ctrl[0] ? voice_level(m_phase, m_vol, m_ctrl[1]) : 0;
            m_mix <= clamp16(m_voice + ((cb2_i && diag_i) ? 2048 : -2048));
            m_acc <= 17'(m_acc[15:0]) + 17'(m_mix + 32768);  // offset binary in
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // mid-cycle compare, away from the edge
    always @(negedge clk_i) begin
        if (cmp_en) begin
            check("audio_o", audio_o, m_acc[16]);
            check("wb_rsp.ack", wb_rsp.ack, m_ack);
            if (wb_rsp.ack) ack_pulses++;
            if (wb_rsp.ack && ack_prev) begin
                errors++;
                $display("ack stayed high for two cycles at %0t ns", $time);
            end
            ack_prev <= wb_rsp.ack;
        end
    end

    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        int waited;
        waited = 0;
        rdat = 8'h00;
        @(posedge clk_i);
        wb_req <= {1'b1, 1'b1, we, adr, wdat};
        accesses++;
        @(negedge clk_i);
        while (!wb_rsp.ack && waited < 16) begin  // ack timeout
            @(negedge clk_i);
            waited++;
        end
        if (!wb_rsp.ack) begin
            errors++;
            $display("no ack from the register decoder at address %0d", adr);
        end else begin
            rdat = wb_rsp.dat;
        end
        @(posedge clk_i);
        wb_req <= '0;  // drop stb after ack
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [7:0] dat);
        bus_cycle(1'b0, adr, 8'h00, dat);
    endtask

    task automatic reset_readback_test();
        logic [7:0] rd;
        logic [7:0] wr [4];
        check("audio_o", audio_o, 1'b0);
        check("wb_rsp.ack", wb_rsp.ack, 1'b0);
        for (int a = 0; a < 4; a++) begin
            wb_read(3'(a), rd);
            check("reset value", rd, 8'h00);
        end
        for (int a = 0; a < 4; a++) begin
            wr[a] = 8'($urandom);
            wb_write(3'(a), wr[a]);
        end
        for (int a = 0; a < 4; a++) begin
            wb_read(3'(a), rd);
            check("readback", rd, wr[a]);
        end
        for (int a = 4; a < 8; a++) begin
            wb_write(3'(a), 8'($urandom));
            wb_read(3'(a), rd);
            check("unmapped read", rd, 8'h00);
        end
    endtask

    task automatic ack_protocol_test();
        logic [7:0] rd;
        idle(2);
        accesses = 0;
        ack_pulses = 0;
        for (int i = 0; i < 8; i++) begin
            if (i[0]) wb_read(3'(i), rd);
            else wb_write(3'(i), 8'($urandom));
        end
        idle(3);  // late ack would show here
        check("ack pulse count", ack_pulses, accesses);
    endtask

    task automatic click_only_test();
        int dut_ones;
        int model_ones;
        dut_ones = 0;
        model_ones = 0;
        wb_write(REG_CTRL, 8'h00);  // voice off
        for (int c = 0; c < 4; c++) begin
            @(posedge clk_i);
            cb2_i <= c[0];
            diag_i <= c[1];
            repeat (128) begin
                @(negedge clk_i);
                dut_ones += int'(audio_o);
                model_ones += int'(m_acc[16]);
            end
        end
        check("ones count", dut_ones, model_ones);
    endtask

    task automatic square_voice_test();
        logic [15:0] freq;
        freq = 16'($urandom_range(16'h0400, 16'h1fff));
        wb_write(REG_FREQ_LO, freq[7:0]);
        wb_write(REG_FREQ_HI, freq[15:8]);
        wb_write(REG_VOLUME, 8'($urandom_range(1, 255)));  // never silent
        wb_write(REG_CTRL, 8'h01);  // enable, square
        repeat (300) begin
            @(posedge clk_i);
            tick_en_i <= 1'($urandom);
        end
    endtask

    task automatic saw_clip_test();
        int clips;
        clips = 0;
        @(posedge clk_i);
        cb2_i <= 1'b1;
        diag_i <= 1'b1;
        tick_en_i <= 1'b1;
        wb_write(REG_VOLUME, 8'hff);
        wb_write(REG_FREQ_HI, 8'(8'h02 + 8'($urandom_range(0, 3))));
        wb_write(REG_CTRL, 8'h03);  // enable, saw
        repeat (300) begin
            @(negedge clk_i);
            if (m_mix == 32767) clips++;
        end
        if (clips == 0) begin
            errors++;
            $display("sawtooth never reached the positive clamp");
        end
    endtask

    task automatic disable_note_test();
        wb_write(REG_CTRL, 8'h01);
        idle(60);
        wb_write(REG_CTRL, 8'h00);  // stop mid-note
        @(negedge clk_i);  // edge after the ack has settled
        check("UUT.voice.phase_q", UUT.voice.phase_q, 16'h0000);
        check("UUT.voice_sample", UUT.voice_sample, 16'h0000);
        idle(40);
    endtask

    initial begin
        void'($urandom(32'ha8ae_580d));
        reset_i = 1'b1;
        tick_en_i = 1'b0;
        cb2_i = 1'b0;
        diag_i = 1'b0;
        wb_req = '0;
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        cmp_en <= 1'b1;
        @(negedge clk_i);
        reset_readback_test();
        ack_protocol_test();
        click_only_test();
        square_voice_test();
        saw_clip_test();
        disable_note_test();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #200_000;  // far beyond the directed run
        $display("simulation watchdog expired, errors so far: %0d", errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* list.f */
src/audio_bus_pkg.sv
src/audio_dsp_pkg.sv
src/audio_reg_decode.sv
src/tone_voice.sv
src/delta_sigma_dac.sv
src/audio_mixer.sv
src/audio_top.sv
sim/audio_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the audio block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module audio_tb -f list.f -o audio_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/audio_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "PASS: all tests"; then
    exit 0
fi
exit 1
